// ==== tb.f ====
source/acc_disp_pkg.sv
source/acc_issue_queue.sv
source/acc_spec_tracker.sv
source/acc_req_stage.sv
source/acc_mem_tracker.sv
source/acc_dispatcher.sv
dv/acc_dispatcher_tb.sv

// ==== Makefile ====
SOURCES := $(wildcard source/*.sv) $(wildcard dv/*.sv)

.PHONY: run clean

run: obj_dir/Vacc_dispatcher_tb
	./obj_dir/Vacc_dispatcher_tb | tee /dev/stderr | grep -q "Simulation completed successfully"

obj_dir/Vacc_dispatcher_tb: tb.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module acc_dispatcher_tb -f tb.f

clean:
	rm -rf obj_dir

// ==== dv/acc_dispatcher_tb.sv ====
/*
  Accelerator dispatcher testbench
  Drives issue, commit, flush and accelerator status, checks requests
  against an in-order model and checks stall and halt rules by assertion
*/
module acc_dispatcher_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import acc_disp_pkg::*;

  localparam int CLK_PERIOD = 100;
  // Upper bound of one test in cycles
  localparam int TEST_LEN   = 300;
  localparam int NR_TESTS   = 6;

  logic                                clk_i;
  logic                                rst_i;
  issue_instr_t                        issue_instr_i;
  logic                                issue_instr_hs_i;
  fu_data_t                            fu_data_i;
  commit_instr_t [NR_COMMIT_PORTS-1:0] commit_instr_i;
  logic                                flush_unissued_instr_i;
  logic                                flush_ex_i;
  logic                                acc_cons_en_i;
  logic [FRM_W-1:0]                    fcsr_frm_i;
  logic                                commit_st_barrier_i;
  logic                                acc_no_st_pending_i;
  acc_resp_t                           acc_resp_i;
  logic                                issue_stall_o;
  logic                                acc_valid_ex_o;
  acc_req_t                            acc_req_o;
  logic                                acc_req_valid_o;
  logic                                ctrl_halt_o;

  // Reference model state
  fu_data_t              sent_data [NR_SB_ENTRIES];
  fu_data_t              exp_q [$];
  logic                  committed [NR_SB_ENTRIES];
  int                    spec_cnt;
  int                    errors;
  int                    tests_run;
  int                    ready_gap;
  logic [TRANS_ID_W-1:0] next_id;

  acc_dispatcher UUT (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_error($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
    end
  endtask

  // Accelerator ready with random gaps, 0 means always ready
  always @(negedge clk_i) begin
    acc_resp_i.req_ready = (ready_gap == 0) || (($urandom % ready_gap) != 0);
  end

  // Every transfer must be the oldest committed instruction
  always @(posedge clk_i) begin
    fu_data_t exp;
    if (!rst_i && acc_req_valid_o && acc_resp_i.req_ready) begin
      if (exp_q.size() == 0) begin
        report_error("Request transferred while no committed instruction was waiting");
      end else begin
        exp = exp_q.pop_front();
        if (!committed[acc_req_o.trans_id]) begin
          report_error("Request transferred for an uncommitted transaction");
        end
        check_value("acc_req_o.trans_id", acc_req_o.trans_id, exp.trans_id);
        check_value("acc_req_o.insn", acc_req_o.insn, exp.imm);
        check_value("acc_req_o.rs1", acc_req_o.rs1, exp.operand_a);
        check_value("acc_req_o.rs2", acc_req_o.rs2, exp.operand_b);
        check_value("acc_req_o.frm", acc_req_o.frm, fcsr_frm_i);
        check_value("acc_req_o.cons_en", acc_req_o.cons_en, acc_cons_en_i);
        check_value("acc_req_o.store_pending", acc_req_o.store_pending,
                    acc_cons_en_i && !acc_no_st_pending_i);
        committed[acc_req_o.trans_id] = 1'b0;
      end
    end
  end

  // Queue full of speculative entries stalls accelerator issue
  always @(posedge clk_i) begin
    if (!rst_i && issue_instr_i.fu == ACCEL && spec_cnt >= 2) begin
      assert (issue_stall_o) else report_error("ACCEL issue not stalled with full queue");
    end
    if (!rst_i && issue_instr_i.fu == LOAD && !acc_cons_en_i) begin
      assert (!issue_stall_o) else report_error("LOAD stalled with consistency off");
    end
  end

  accept_to_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    1'b1 |=> acc_valid_ex_o == $past(issue_instr_hs_i && issue_instr_i.fu == ACCEL &&
      !issue_instr_i.ex_valid && !flush_unissued_instr_i))
    else report_error("acc_valid_ex_o does not follow the accepted handshake");
  req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_req_valid_o && !acc_resp_i.req_ready |=> acc_req_valid_o && $stable(acc_req_o))
    else report_error("Request changed while stalled by the accelerator");
  halt_set: assert property (@(posedge clk_i) disable iff (rst_i)
    commit_st_barrier_i && acc_resp_i.store_pending |=> ctrl_halt_o)
    else report_error("ctrl_halt_o did not rise after a store barrier");
  halt_hold_high: assert property (@(posedge clk_i) disable iff (rst_i)
    ctrl_halt_o && acc_resp_i.store_pending |=> ctrl_halt_o)
    else report_error("ctrl_halt_o fell while stores were still pending");
  halt_clear: assert property (@(posedge clk_i) disable iff (rst_i)
    !acc_resp_i.store_pending |=> !ctrl_halt_o)
    else report_error("ctrl_halt_o stayed high without pending stores");
  halt_hold_low: assert property (@(posedge clk_i) disable iff (rst_i)
    !commit_st_barrier_i && !ctrl_halt_o |=> !ctrl_halt_o)
    else report_error("ctrl_halt_o rose without a store barrier");

  // Handshake, then operands in the push cycle
  task automatic issue(input acc_op_e op, output logic [TRANS_ID_W-1:0] id);
    id = next_id;
    next_id++;
    issue_instr_i    = '{ex_valid: 1'b0, fu: ACCEL, op: op, trans_id: id};
    issue_instr_hs_i = 1'b1;
    @(negedge clk_i);
    issue_instr_hs_i = 1'b0;
    fu_data_i = '{operation: op, operand_a: $urandom, operand_b: $urandom,
                  imm: $urandom, trans_id: id};
    sent_data[id] = fu_data_i;
    @(negedge clk_i);
    spec_cnt++;
  endtask

  // Commit at port 0 as the scoreboard head
  task automatic commit(input logic [TRANS_ID_W-1:0] id);
    commit_instr_i[0] = '{valid: 1'b0, fu: ACCEL, trans_id: id};
    exp_q.push_back(sent_data[id]);
    committed[id] = 1'b1;
    spec_cnt--;
    @(negedge clk_i);
    commit_instr_i[0] = '{valid: 1'b0, fu: NONE, trans_id: '0};
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || acc_req_valid_o) && n < TEST_LEN) begin
      @(negedge clk_i);
      n++;
    end
    if (n == TEST_LEN) begin
      report_error("Committed requests did not reach the accelerator in time");
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    $display("Test %0d %s: %s", tests_run, name, (errors == errors_before) ? "PASS" : "FAIL");
  endtask

  initial begin
    #(NR_TESTS * TEST_LEN * 2 * CLK_PERIOD);
    $display("Timeout: the run did not finish within its time limit");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [TRANS_ID_W-1:0] ids [4];
    int e;
    void'($urandom(54714));
    clk_i = 1'b0;
    rst_i = 1'b1;
    issue_instr_i = '{ex_valid: 1'b0, fu: NONE, op: ACCEL_OP, trans_id: '0};
    issue_instr_hs_i = 1'b0;
    fu_data_i = '0;
    commit_instr_i = '0;
    flush_unissued_instr_i = 1'b0;
    flush_ex_i = 1'b0;
    acc_cons_en_i = 1'b0;
    fcsr_frm_i = $urandom;
    commit_st_barrier_i = 1'b0;
    acc_no_st_pending_i = 1'b1;
    acc_resp_i = '{req_ready: 1'b1, default: 1'b0};
    ready_gap = 0;
    next_id = '0;
    spec_cnt = 0;
    errors = 0;
    tests_run = 0;
    foreach (committed[i]) committed[i] = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;

    // Order and content, commits right behind issue
    e = errors;
    ready_gap = 3;
    for (int i = 0; i < 6; i++) begin
      issue(ACCEL_OP, ids[0]);
      commit(ids[0]);
    end
    wait_drain();
    finish_test("order and content", e);

    // Uncommitted entry stays in the queue
    e = errors;
    // Exception, flushed and non-accelerator handshakes are all refused
    issue_instr_i    = '{ex_valid: 1'b1, fu: ACCEL, op: ACCEL_OP, trans_id: next_id};
    issue_instr_hs_i = 1'b1;
    @(negedge clk_i);
    issue_instr_i.ex_valid = 1'b0;
    flush_unissued_instr_i = 1'b1;
    @(negedge clk_i);
    flush_unissued_instr_i = 1'b0;
    issue_instr_i.fu       = ALU;
    @(negedge clk_i);
    issue_instr_hs_i = 1'b0;
    issue_instr_i.fu = ACCEL;
    issue(ACCEL_OP, ids[0]);
    repeat ($urandom % 20 + 5) @(negedge clk_i);
    commit(ids[0]);
    wait_drain();
    finish_test("no speculative dispatch", e);

    // Flushed entries vanish, later ones still go
    e = errors;
    issue(ACCEL_OP, ids[0]);
    issue(ACCEL_OP, ids[1]);
    flush_ex_i = 1'b1;
    spec_cnt = 0;
    @(negedge clk_i);
    flush_ex_i = 1'b0;
    issue(ACCEL_OP, ids[2]);
    commit(ids[2]);
    issue(ACCEL_OP, ids[3]);
    commit(ids[3]);
    wait_drain();
    finish_test("flush", e);

    // Heavy back-pressure and a full queue
    e = errors;
    ready_gap = 2;
    issue(ACCEL_OP, ids[0]);
    issue(ACCEL_OP, ids[1]);
    @(posedge clk_i);
    assert (issue_stall_o) else report_error("ACCEL issue not stalled with two queued");
    @(negedge clk_i);
    commit(ids[0]);
    commit(ids[1]);
    for (int i = 0; i < 4; i++) begin
      issue(ACCEL_OP, ids[0]);
      commit(ids[0]);
    end
    wait_drain();
    ready_gap = 0;
    finish_test("back-pressure", e);

    // Scalar load waits behind an accelerator store
    e = errors;
    acc_cons_en_i = 1'b1;
    acc_no_st_pending_i = 1'b0;
    issue(ACCEL_OP_STORE, ids[0]);
    commit(ids[0]);
    wait_drain();
    issue_instr_i.fu = LOAD;
    @(posedge clk_i);
    assert (issue_stall_o) else report_error("LOAD not stalled behind a pending store");
    @(negedge clk_i);
    // Store still outstanding, consistency off
    acc_cons_en_i = 1'b0;
    repeat (2) @(negedge clk_i);
    acc_cons_en_i = 1'b1;
    acc_resp_i.store_complete = 1'b1;
    @(negedge clk_i);
    acc_resp_i.store_complete = 1'b0;
    @(posedge clk_i);
    assert (!issue_stall_o) else report_error("LOAD still stalled after store_complete");
    @(negedge clk_i);
    acc_cons_en_i = 1'b0;
    acc_no_st_pending_i = 1'b1;
    issue_instr_i.fu = NONE;
    finish_test("consistency stall", e);

    // Store barrier with stores still pending
    e = errors;
    acc_resp_i.store_pending = 1'b1;
    repeat (3) @(negedge clk_i);
    commit_st_barrier_i = 1'b1;
    @(negedge clk_i);
    commit_st_barrier_i = 1'b0;
    repeat ($urandom % 8 + 2) @(negedge clk_i);
    acc_resp_i.store_pending = 1'b0;
    repeat (4) @(negedge clk_i);
    finish_test("barrier halt", e);

    $display("Tests run: %0d, checks failed: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== source/acc_dispatcher.sv ====
/*
  Accelerator dispatcher
  Queues accelerator instructions from the issue stage and sends them to
  the accelerator once they are no longer speculative
*/
module acc_dispatcher (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  acc_disp_pkg::issue_instr_t          issue_instr_i,
  input  logic                                issue_instr_hs_i,
  input  acc_disp_pkg::fu_data_t              fu_data_i,
  input  acc_disp_pkg::commit_instr_t [acc_disp_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic                                flush_unissued_instr_i,
  input  logic                                flush_ex_i,
  input  logic                                acc_cons_en_i,
  input  logic [acc_disp_pkg::FRM_W-1:0]      fcsr_frm_i,
  input  logic                                commit_st_barrier_i,
  input  logic                                acc_no_st_pending_i,
  input  acc_disp_pkg::acc_resp_t             acc_resp_i,
  output logic                                issue_stall_o,
  output logic                                acc_valid_ex_o,
  output acc_disp_pkg::acc_req_t              acc_req_o,
  output logic                                acc_req_valid_o,
  output logic                                ctrl_halt_o
);
  import acc_disp_pkg::*;

  logic     accept;
  acc_op_e  accept_op;
  fu_data_t head;
  logic     empty;
  logic     queue_ready;
  logic     pop;
  logic     head_go;
  logic     ld_disp;
  logic     st_disp;

  acc_issue_queue i_issue_queue (
    .clk_i                  (clk_i),
    .rst_i                  (rst_i),
    .issue_instr_i          (issue_instr_i),
    .issue_instr_hs_i       (issue_instr_hs_i),
    .flush_unissued_instr_i (flush_unissued_instr_i),
    .flush_ex_i             (flush_ex_i),
    .fu_data_i              (fu_data_i),
    .pop_i                  (pop),
    .acc_valid_ex_o         (acc_valid_ex_o),
    .accept_o               (accept),
    .accept_op_o            (accept_op),
    .head_o                 (head),
    .empty_o                (empty),
    .ready_o                (queue_ready)
  );

  // Pushed ID is the registered operand set, sent ID is the popped head
  acc_spec_tracker i_spec_tracker (
    .clk_i                  (clk_i),
    .rst_i                  (rst_i),
    .flush_ex_i             (flush_ex_i),
    .push_i                 (acc_valid_ex_o),
    .push_id_i              (fu_data_i.trans_id),
    .commit_instr_i         (commit_instr_i),
    .sent_i                 (pop),
    .sent_id_i              (head.trans_id),
    .head_id_i              (head.trans_id),
    .flush_unissued_instr_i (flush_unissued_instr_i),
    .head_go_o              (head_go)
  );

  acc_req_stage i_req_stage (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .head_i              (head),
    .empty_i             (empty),
    .head_go_i           (head_go),
    .fcsr_frm_i          (fcsr_frm_i),
    .acc_cons_en_i       (acc_cons_en_i),
    .acc_no_st_pending_i (acc_no_st_pending_i),
    .req_ready_i         (acc_resp_i.req_ready),
    .pop_o               (pop),
    .ld_disp_o           (ld_disp),
    .st_disp_o           (st_disp),
    .acc_req_o           (acc_req_o),
    .acc_req_valid_o     (acc_req_valid_o)
  );

  acc_mem_tracker i_mem_tracker (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .flush_ex_i          (flush_ex_i),
    .accept_i            (accept),
    .accept_op_i         (accept_op),
    .ld_disp_i           (ld_disp),
    .st_disp_i           (st_disp),
    .acc_resp_i          (acc_resp_i),
    .acc_cons_en_i       (acc_cons_en_i),
    .issue_fu_i          (issue_instr_i.fu),
    .queue_ready_i       (queue_ready),
    .commit_st_barrier_i (commit_st_barrier_i),
    .issue_stall_o       (issue_stall_o),
    .ctrl_halt_o         (ctrl_halt_o)
  );

endmodule

// ==== source/acc_mem_tracker.sv ====
/*
  Accelerator memory tracker
  Counts speculative and dispatched accelerator loads and stores, stalls
  scalar memory issue for consistency and halts on a store barrier
*/
module acc_mem_tracker (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_ex_i,
  input  logic                  accept_i,
  input  acc_disp_pkg::acc_op_e accept_op_i,
  input  logic                  ld_disp_i,
  input  logic                  st_disp_i,
  input  acc_disp_pkg::acc_resp_t acc_resp_i,
  input  logic                  acc_cons_en_i,
  input  acc_disp_pkg::fu_e     issue_fu_i,
  input  logic                  queue_ready_i,
  input  logic                  commit_st_barrier_i,
  output logic                  issue_stall_o,
  output logic                  ctrl_halt_o
);
  import acc_disp_pkg::*;

  logic [CNT_W-1:0] spec_ld_q;
  logic [CNT_W-1:0] spec_st_q;
  logic [CNT_W-1:0] disp_ld_q;
  logic [CNT_W-1:0] disp_st_q;
  logic             spec_ld_up;
  logic             spec_st_up;
  logic             ld_pending;
  logic             st_pending;
  logic             halt_q;

  // Up and down together cancel out
  function automatic logic [CNT_W-1:0] count_next(
    input logic [CNT_W-1:0] cnt,
    input logic             up,
    input logic             down
  );
    if (up && !down) begin
      count_next = cnt + 1'b1;
    end else if (down && !up) begin
      count_next = cnt - 1'b1;
    end else begin
      count_next = cnt;
    end
  endfunction

  assign spec_ld_up = accept_i && (accept_op_i == ACCEL_OP_LOAD);
  assign spec_st_up = accept_i && (accept_op_i == ACCEL_OP_STORE);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      spec_ld_q <= '0;
      spec_st_q <= '0;
      disp_ld_q <= '0;
      disp_st_q <= '0;
    end else begin
      // Speculative counts can still be flushed
      if (flush_ex_i) begin
        spec_ld_q <= '0;
        spec_st_q <= '0;
      end else begin
        spec_ld_q <= count_next(spec_ld_q, spec_ld_up, ld_disp_i);
        spec_st_q <= count_next(spec_st_q, spec_st_up, st_disp_i);
      end
      // Dispatched ones wait for the accelerator to complete
      disp_ld_q <= count_next(disp_ld_q, ld_disp_i, acc_resp_i.load_complete);
      disp_st_q <= count_next(disp_st_q, st_disp_i, acc_resp_i.store_complete);
    end
  end

  assign ld_pending = (spec_ld_q != '0) || (disp_ld_q != '0);
  assign st_pending = (spec_st_q != '0) || (disp_st_q != '0);

  always_comb begin
    case (issue_fu_i)
      // Dispatcher queue has no room
      ACCEL:   issue_stall_o = !queue_ready_i;
      // Scalar load behind an accelerator store
      LOAD:    issue_stall_o = acc_cons_en_i && st_pending;
      // Scalar store behind any accelerator memory op
      STORE:   issue_stall_o = acc_cons_en_i && (st_pending || ld_pending);
      default: issue_stall_o = 1'b0;
    endcase
  end

  // Set on barrier, kept while the accelerator still has stores in flight
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      halt_q <= 1'b0;
    end else begin
      halt_q <= (halt_q || commit_st_barrier_i) && acc_resp_i.store_pending;
    end
  end

  assign ctrl_halt_o = halt_q;

endmodule

// ==== source/acc_req_stage.sv ====
/*
  Accelerator request stage
  Builds a request from the queue head and holds it in a two-entry spill
  register that follows the accelerator valid/ready rule
*/
module acc_req_stage (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  acc_disp_pkg::fu_data_t             head_i,
  input  logic                               empty_i,
  input  logic                               head_go_i,
  input  logic [acc_disp_pkg::FRM_W-1:0]     fcsr_frm_i,
  input  logic                               acc_cons_en_i,
  input  logic                               acc_no_st_pending_i,
  input  logic                               req_ready_i,
  output logic                               pop_o,
  output logic                               ld_disp_o,
  output logic                               st_disp_o,
  output acc_disp_pkg::acc_req_t             acc_req_o,
  output logic                               acc_req_valid_o
);
  import acc_disp_pkg::*;

  acc_req_t req;
  logic     req_valid;
  logic     spill_ready;
  logic     a_full_q;
  logic     b_full_q;
  acc_req_t a_data_q;
  acc_req_t b_data_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  // Instruction word travels in the immediate field
  assign req.insn          = head_i.imm[31:0];
  assign req.rs1           = head_i.operand_a;
  assign req.rs2           = head_i.operand_b;
  // Rounding mode is current since fcsr writes wait for the accelerator
  assign req.frm           = fcsr_frm_i;
  assign req.trans_id      = head_i.trans_id;
  assign req.store_pending = acc_cons_en_i && !acc_no_st_pending_i;
  assign req.cons_en       = acc_cons_en_i;

  // Head leaves only once it is non-speculative
  assign req_valid = !empty_i && head_go_i;
  assign pop_o     = req_valid && spill_ready;
  assign ld_disp_o = pop_o && (head_i.operation == ACCEL_OP_LOAD);
  assign st_disp_o = pop_o && (head_i.operation == ACCEL_OP_STORE);

  // Slot A takes new requests, slot B holds the older one under stall
  assign a_fill  = req_valid && spill_ready;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !req_ready_i;
  assign b_drain = b_full_q && req_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= req;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  assign spill_ready     = !a_full_q || !b_full_q;
  assign acc_req_valid_o = a_full_q || b_full_q;
  // Oldest entry goes out first
  assign acc_req_o       = b_full_q ? b_data_q : a_data_q;

endmodule

// ==== source/acc_spec_tracker.sv ====
/*
  Speculation tracker
  Marks received transaction IDs as pending, promotes them to ready once
  the commit stage shows them at the scoreboard head
*/
module acc_spec_tracker (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    flush_ex_i,
  input  logic                                    push_i,
  input  logic [acc_disp_pkg::TRANS_ID_W-1:0]     push_id_i,
  input  acc_disp_pkg::commit_instr_t [acc_disp_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic                                    sent_i,
  input  logic [acc_disp_pkg::TRANS_ID_W-1:0]     sent_id_i,
  input  logic [acc_disp_pkg::TRANS_ID_W-1:0]     head_id_i,
  input  logic                                    flush_unissued_instr_i,
  output logic                                    head_go_o
);
  import acc_disp_pkg::*;

  logic [NR_SB_ENTRIES-1:0] pending_q;
  logic [NR_SB_ENTRIES-1:0] pending_d;
  logic [NR_SB_ENTRIES-1:0] ready_q;
  logic [NR_SB_ENTRIES-1:0] ready_d;
  logic                     commit;
  logic                     commit_hit;
  logic [TRANS_ID_W-1:0]    commit_id;

  // An accelerator op waits at the first commit port that is not valid
  always_comb begin
    commit = 1'b0;
    if (!commit_instr_i[0].valid && (commit_instr_i[0].fu == ACCEL)) begin
      commit = 1'b1;
    end
    if (commit_instr_i[0].valid && !commit_instr_i[1].valid &&
        (commit_instr_i[1].fu == ACCEL)) begin
      commit = 1'b1;
    end
  end

  assign commit_id  = !commit_instr_i[0].valid ? commit_instr_i[0].trans_id
                                               : commit_instr_i[1].trans_id;
  assign commit_hit = commit && pending_q[commit_id];

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    // Newly pushed instruction is speculative
    if (push_i) begin
      pending_d[push_id_i] = 1'b1;
    end
    if (flush_ex_i) begin
      pending_d = '0;
    end
    // No longer speculative
    if (commit_hit) begin
      ready_d[commit_id]   = 1'b1;
      pending_d[commit_id] = 1'b0;
    end
    // Left the queue
    if (sent_i) begin
      ready_d[sent_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

  // Stored ready bit, or same-cycle commit bypass
  assign head_go_o = ready_q[head_id_i] || (commit_hit && !flush_unissued_instr_i);

endmodule

// ==== source/acc_issue_queue.sv ====
/*
  Accelerator instruction queue
  Registers the accept decision for issued accelerator instructions and
  keeps their operands in a three-entry fall-through ring buffer
*/
module acc_issue_queue (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  acc_disp_pkg::issue_instr_t issue_instr_i,
  input  logic                       issue_instr_hs_i,
  input  logic                       flush_unissued_instr_i,
  input  logic                       flush_ex_i,
  input  acc_disp_pkg::fu_data_t     fu_data_i,
  input  logic                       pop_i,
  output logic                       acc_valid_ex_o,
  output logic                       accept_o,
  output acc_disp_pkg::acc_op_e      accept_op_o,
  output acc_disp_pkg::fu_data_t     head_o,
  output logic                       empty_o,
  output logic                       ready_o
);
  import acc_disp_pkg::*;

  logic                             valid_q;
  fu_data_t                         mem_q [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(QUEUE_DEPTH+1)-1:0] usage_q;
  logic                             full;
  logic                             do_write;
  logic                             do_read;

  // Ring pointer step, wraps at the queue depth
  function automatic logic [$clog2(QUEUE_DEPTH)-1:0] ptr_inc(
    input logic [$clog2(QUEUE_DEPTH)-1:0] ptr
  );
    ptr_inc = (ptr == QUEUE_DEPTH - 1) ? '0 : ptr + 1'b1;
  endfunction

  // Issued, accelerator bound, no exception and not being flushed
  assign accept_o    = issue_instr_hs_i && (issue_instr_i.fu == ACCEL) &&
                       !issue_instr_i.ex_valid && !flush_unissued_instr_i;
  assign accept_op_o = issue_instr_i.op;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept_o;
    end
  end

  // Operands arrive one cycle after the handshake, together with the push
  assign acc_valid_ex_o = valid_q;

  assign full     = (usage_q == QUEUE_DEPTH);
  assign do_read  = pop_i && (usage_q != '0);
  // Push straight through when empty and popped in the same cycle
  assign do_write = valid_q && !full && !(pop_i && (usage_q == '0));

  assign empty_o = (usage_q == '0) && !valid_q;
  assign head_o  = (usage_q == '0) ? fu_data_i : mem_q[rd_ptr_q];
  // Room for at least one more entry beyond the one in flight
  assign ready_o = usage_q < QUEUE_DEPTH - 1;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_ex_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_read) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (do_write && !do_read) begin
        usage_q <= usage_q + 1'b1;
      end else if (do_read && !do_write) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  // Operand storage
  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem_q[wr_ptr_q] <= fu_data_i;
    end
  end

endmodule

// ==== source/acc_disp_pkg.sv ====
/*
  Accelerator dispatcher package
  Widths, enums and packed structs shared by the dispatcher blocks
*/
package acc_disp_pkg;

  // Core and accelerator widths
  localparam int XLEN            = 32;
  localparam int FRM_W           = 3;
  // Scoreboard geometry
  localparam int NR_SB_ENTRIES   = 8;
  localparam int TRANS_ID_W      = 3;
  localparam int NR_COMMIT_PORTS = 2;
  // Dispatcher sizing
  localparam int QUEUE_DEPTH     = 3;
  localparam int CNT_W           = 3;

  // Functional unit of an issued or committed instruction
  typedef enum logic [2:0] {
    NONE  = 3'd0,
    LOAD  = 3'd1,
    STORE = 3'd2,
    ACCEL = 3'd3,
    ALU   = 3'd4
  } fu_e;

  // Accelerator operation class, only loads and stores matter for ordering
  typedef enum logic [1:0] {
    ACCEL_OP       = 2'd0,
    ACCEL_OP_LOAD  = 2'd1,
    ACCEL_OP_STORE = 2'd2
  } acc_op_e;

  typedef struct packed {
    logic                  ex_valid;
    fu_e                   fu;
    acc_op_e               op;
    logic [TRANS_ID_W-1:0] trans_id;
  } issue_instr_t;

  typedef struct packed {
    acc_op_e               operation;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       imm;
    logic [TRANS_ID_W-1:0] trans_id;
  } fu_data_t;

  typedef struct packed {
    logic                  valid;
    fu_e                   fu;
    logic [TRANS_ID_W-1:0] trans_id;
  } commit_instr_t;

  typedef struct packed {
    logic [31:0]           insn;
    logic [XLEN-1:0]       rs1;
    logic [XLEN-1:0]       rs2;
    logic [FRM_W-1:0]      frm;
    logic [TRANS_ID_W-1:0] trans_id;
    logic                  store_pending;
    logic                  cons_en;
  } acc_req_t;

  typedef struct packed {
    logic req_ready;
    logic load_complete;
    logic store_complete;
    logic store_pending;
  } acc_resp_t;

endpackage
